// File: include/pu_config.svh
`ifndef PU_CONFIG_SVH
`define PU_CONFIG_SVH

// ==============================
// datapath sizes
// ==============================
`define PU_DATA_WIDTH  32   // must be a multiple of PU_DIV_STAGES
`define PU_ATTR_WIDTH  4    // attribute word is one bit wider than this
`define PU_INVALID_BIT 0
`define PU_DIV_STAGES  4

// ==============================
// register offsets
// ==============================
`define PU_ADDR_NUMER     8'h00
`define PU_ADDR_DENOM     8'h04
`define PU_ADDR_NUMER_INV 8'h08
`define PU_ADDR_DENOM_INV 8'h0C
`define PU_ADDR_QUOT      8'h10
`define PU_ADDR_REM       8'h14

`endif

// File: src/pu_pkg.sv
`include "pu_config.svh"

package pu_pkg;

  // operands and results share one width
  typedef logic [`PU_DATA_WIDTH-1:0] data_t;

  // attribute word, flag sits at PU_INVALID_BIT
  typedef logic [`PU_ATTR_WIDTH:0] attr_t;

  typedef logic [7:0] apb_addr_t;  // byte address on the APB side

  // write completes in its first access cycle, a read takes one wait state
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITE,
    ST_READ_WAIT,
    ST_READ_DONE
  } bridge_state_t;

endpackage

// File: src/pu_bus_if.sv
interface pu_bus_if #(
  parameter type data_t = logic,
  parameter type attr_t = logic
);

  logic  signal_wr;      // single-cycle write pulse
  logic  signal_wr_sel;  // low latches the numerator, high commits the pair
  data_t data_in;
  attr_t attr_in;

  logic  signal_oe;      // held for the whole read
  logic  signal_oe_sel;  // high picks the quotient
  data_t data_out;
  attr_t attr_out;

  modport ctrl (
    output signal_wr, signal_wr_sel, data_in, attr_in,
    output signal_oe, signal_oe_sel,
    input  data_out, attr_out
  );

  modport unit (
    input  signal_wr, signal_wr_sel, data_in, attr_in,
    input  signal_oe, signal_oe_sel,
    output data_out, attr_out
  );

endinterface

// File: src/div_pipe.sv
`include "pu_config.svh"

module div_pipe (
  input  logic          clk,
  input  logic          rst,
  input  pu_pkg::data_t numer,
  input  pu_pkg::data_t denom,
  output pu_pkg::data_t quotient,
  output pu_pkg::data_t remain
);

  localparam int WIDTH  = `PU_DATA_WIDTH;
  localparam int STAGES = `PU_DIV_STAGES;
  localparam int STEPS  = WIDTH / STAGES;

  for (genvar s = 0; s < STAGES; s++) begin : g_stage
    pu_pkg::data_t rem_in;
    pu_pkg::data_t qn_in;    // numerator bits on top, quotient bits shift in below
    pu_pkg::data_t div_in;
    pu_pkg::data_t rem_nx;
    pu_pkg::data_t qn_nx;
    pu_pkg::data_t rem_q;
    pu_pkg::data_t qn_q;
    pu_pkg::data_t div_q;

    if (s == 0) begin : g_first
      assign rem_in = '0;
      assign qn_in  = numer;
      assign div_in = denom;
    end else begin : g_next
      assign rem_in = g_stage[s-1].rem_q;
      assign qn_in  = g_stage[s-1].qn_q;
      assign div_in = g_stage[s-1].div_q;
    end

    // restoring shift-subtract, STEPS bits per stage
    always_comb begin
      logic [WIDTH:0] trial;
      rem_nx = rem_in;
      qn_nx  = qn_in;
      for (int i = 0; i < STEPS; i++) begin
        trial = {rem_nx, qn_nx[WIDTH-1]};
        if (trial >= {1'b0, div_in}) begin
          trial = trial - {1'b0, div_in};
          qn_nx = {qn_nx[WIDTH-2:0], 1'b1};
        end else begin
          qn_nx = {qn_nx[WIDTH-2:0], 1'b0};
        end
        rem_nx = trial[WIDTH-1:0];  // always below the divisor after the step
      end
    end

    always_ff @(posedge clk) begin
      if (rst) begin
        rem_q <= '0;
        qn_q  <= '0;
        div_q <= '0;
      end else begin
        rem_q <= rem_nx;
        qn_q  <= qn_nx;
        div_q <= div_in;  // divisor travels with its item
      end
    end
  end

  // a zero divisor ends up as all ones and the numerator
  assign quotient = g_stage[STAGES-1].qn_q;
  assign remain   = g_stage[STAGES-1].rem_q;

endmodule

// File: src/pu_div.sv
`include "pu_config.svh"

module pu_div (
  input logic    clk,
  input logic    rst,
  pu_bus_if.unit bus
);

  localparam int STAGES = `PU_DIV_STAGES;

  // ==============================
  // operand latch
  // ==============================
  pu_pkg::data_t numer_latch;
  pu_pkg::attr_t attr_latch;
  pu_pkg::data_t arg_numer;
  pu_pkg::data_t arg_denom;
  pu_pkg::attr_t attr_numer;
  pu_pkg::attr_t attr_denom;

  always_ff @(posedge clk) begin
    if (rst) begin
      numer_latch <= '0;
      attr_latch  <= '0;
      arg_numer   <= '0;  // zero pair leaves a divide-by-zero in the pipe
      arg_denom   <= '0;
      attr_numer  <= '0;
      attr_denom  <= '0;
    end else if (bus.signal_wr && !bus.signal_wr_sel) begin
      numer_latch <= bus.data_in;
      attr_latch  <= bus.attr_in;
    end else if (bus.signal_wr) begin
      // second write commits both operands at once
      arg_numer  <= numer_latch;
      attr_numer <= attr_latch;
      arg_denom  <= bus.data_in;
      attr_denom <= bus.attr_in;
    end
  end

  // ==============================
  // invalid flag delay line
  // ==============================
  logic [STAGES-1:0] attr_wait;
  logic              pair_invalid;

  assign pair_invalid = attr_numer[`PU_INVALID_BIT] || attr_denom[`PU_INVALID_BIT]
                        || (arg_denom == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      attr_wait <= '0;
    end else begin
      attr_wait <= {attr_wait[STAGES-2:0], pair_invalid};
    end
  end

  pu_pkg::data_t quotient_result;
  pu_pkg::data_t remain_result;

  div_pipe u_div (
    .clk      (clk),
    .rst      (rst),
    .numer    (arg_numer),
    .denom    (arg_denom),
    .quotient (quotient_result),
    .remain   (remain_result)
  );

  // ==============================
  // output register
  // ==============================
  logic          invalid_result;
  pu_pkg::data_t data_divresult;

  always_ff @(posedge clk) begin
    if (rst) begin
      invalid_result <= 1'b0;
      data_divresult <= '0;
    end else if (bus.signal_oe) begin
      invalid_result <= attr_wait[STAGES-1];  // lines up with the divider outputs
      data_divresult <= bus.signal_oe_sel ? quotient_result : remain_result;
    end
  end

  assign bus.data_out = bus.signal_oe ? data_divresult : '0;
  assign bus.attr_out = bus.signal_oe ?
                        (pu_pkg::attr_t'(invalid_result) << `PU_INVALID_BIT) : '0;

endmodule

// File: src/apb_pu_bridge.sv
`include "pu_config.svh"

module apb_pu_bridge (
  input  logic              clk,
  input  logic              rst,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  pu_pkg::apb_addr_t paddr,
  input  pu_pkg::data_t     pwdata,
  output pu_pkg::data_t     prdata,
  output logic              pready,
  output logic              pslverr,
  pu_bus_if.ctrl            bus
);

  pu_pkg::bridge_state_t state;

  logic is_oper, is_result, is_denom, is_inv, is_quot;
  logic setup;
  logic wr_hit, oe_hit, err_q, wr_sel_q, oe_sel_q;
  pu_pkg::data_t data_q;
  pu_pkg::attr_t attr_q;

  // offset decode, anything else is unmapped
  always_comb begin
    is_oper   = 1'b0;
    is_result = 1'b0;
    is_denom  = 1'b0;
    is_inv    = 1'b0;
    is_quot   = 1'b0;
    case (paddr)
      `PU_ADDR_NUMER:     is_oper = 1'b1;
      `PU_ADDR_DENOM:     begin is_oper = 1'b1; is_denom = 1'b1; end
      `PU_ADDR_NUMER_INV: begin is_oper = 1'b1; is_inv = 1'b1; end
      `PU_ADDR_DENOM_INV: begin is_oper = 1'b1; is_denom = 1'b1; is_inv = 1'b1; end
      `PU_ADDR_QUOT:      begin is_result = 1'b1; is_quot = 1'b1; end
      `PU_ADDR_REM:       is_result = 1'b1;
      default:            ;
    endcase
  end

  assign setup = (state == pu_pkg::ST_IDLE) && psel && !penable;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= pu_pkg::ST_IDLE;
      wr_hit   <= 1'b0;
      oe_hit   <= 1'b0;
      err_q    <= 1'b0;
      wr_sel_q <= 1'b0;
      oe_sel_q <= 1'b0;
    end else begin
      case (state)
        pu_pkg::ST_IDLE: if (setup) begin
          state    <= pwrite ? pu_pkg::ST_WRITE : pu_pkg::ST_READ_WAIT;
          wr_hit   <= pwrite && is_oper;    // writes to result offsets are dropped
          oe_hit   <= !pwrite && is_result;
          err_q    <= !(is_oper || is_result);
          wr_sel_q <= is_denom;
          oe_sel_q <= is_quot;
        end
        pu_pkg::ST_READ_WAIT: state <= pu_pkg::ST_READ_DONE;
        default:              state <= pu_pkg::ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (setup) begin
      data_q <= pwdata;
      attr_q <= pu_pkg::attr_t'(is_inv) << `PU_INVALID_BIT;
    end
  end

  assign bus.signal_wr     = (state == pu_pkg::ST_WRITE) && wr_hit;
  assign bus.signal_wr_sel = wr_sel_q;
  assign bus.data_in       = data_q;
  assign bus.attr_in       = attr_q;
  assign bus.signal_oe     = (state == pu_pkg::ST_READ_WAIT || state == pu_pkg::ST_READ_DONE)
                             && oe_hit;
  assign bus.signal_oe_sel = oe_sel_q;

  assign pready  = (state == pu_pkg::ST_WRITE) || (state == pu_pkg::ST_READ_DONE);
  assign prdata  = (state == pu_pkg::ST_READ_DONE) ? bus.data_out : '0;
  assign pslverr = ((state == pu_pkg::ST_WRITE) && err_q) ||
                   ((state == pu_pkg::ST_READ_DONE) && (err_q || bus.attr_out[`PU_INVALID_BIT]));

endmodule

// File: src/pu_div_apb_top.sv
module pu_div_apb_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  pu_pkg::apb_addr_t paddr,
  input  pu_pkg::data_t     pwdata,
  output pu_pkg::data_t     prdata,
  output logic              pready,
  output logic              pslverr
);

  // strobes between the bridge and the unit
  pu_bus_if #(
    .data_t (pu_pkg::data_t),
    .attr_t (pu_pkg::attr_t)
  ) bus_if ();

  apb_pu_bridge u_bridge (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .bus     (bus_if.ctrl)
  );

  pu_div u_pu (
    .clk (clk),
    .rst (rst),
    .bus (bus_if.unit)
  );

endmodule

// File: verification/tb_pu_div.sv
`include "pu_config.svh"

module tb_pu_div;

  localparam int STAGES       = `PU_DIV_STAGES;
  localparam int RANDOM_PAIRS = 60;
  localparam int PAIR_CYCLES  = 16;  // two writes, the latency wait and two reads
  // random pairs dominate the run, three times their length leaves room for the rest
  localparam int MAX_CYCLES   = 3 * RANDOM_PAIRS * PAIR_CYCLES + 120;

  logic              clk;
  logic              rst;
  logic              psel;
  logic              penable;
  logic              pwrite;
  pu_pkg::apb_addr_t paddr;
  pu_pkg::data_t     pwdata;
  pu_pkg::data_t     prdata;
  logic              pready;
  logic              pslverr;

  integer seed;
  int     cycles = 0;

  pu_div_apb_top dut0 (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES)
      stop_on_error($sformatf("run did not finish within %0d cycles", MAX_CYCLES));
  end

  // ==============================
  // checking helpers
  // ==============================
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input pu_pkg::data_t got,
                             input pu_pkg::data_t exp);
    assert (got === exp)
      else stop_on_error($sformatf("error: %s is %h, expected %h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    assert (got === exp)
      else stop_on_error($sformatf("error: %s is %h, expected %h", name, got, exp));
  endtask

  // ==============================
  // APB driver
  // ==============================
  // both tasks start and end on a falling edge, so calls run back to back
  task automatic apb_write(input pu_pkg::apb_addr_t addr, input pu_pkg::data_t data,
                           output logic err, output pu_pkg::data_t rdata);
    int waits;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    waits   = 0;
    while (!pready) begin
      @(negedge clk);
      waits++;
      if (waits > 8)
        stop_on_error("pready never rose during a write access phase");
    end
    err   = pslverr;
    rdata = prdata;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    check_value("write wait states", waits, 0);
  endtask

  task automatic apb_read(input pu_pkg::apb_addr_t addr, output pu_pkg::data_t rdata,
                          output logic err);
    int waits;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;
    waits   = 0;
    while (!pready) begin
      @(negedge clk);
      waits++;
      if (waits > 8)
        stop_on_error("pready never rose during a read access phase");
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    check_value("read wait states", waits, 1);  // the unit registers during the wait
  endtask

  task automatic write_ok(input pu_pkg::apb_addr_t addr, input pu_pkg::data_t data);
    logic          err;
    pu_pkg::data_t rdata;
    apb_write(addr, data, err, rdata);
    check_flag("pslverr on operand write", err, 1'b0);
  endtask

  task automatic commit_pair(input pu_pkg::apb_addr_t naddr, input pu_pkg::data_t n,
                             input pu_pkg::apb_addr_t daddr, input pu_pkg::data_t d);
    write_ok(naddr, n);
    write_ok(daddr, d);
  endtask

  task automatic check_division(input pu_pkg::data_t n, input pu_pkg::data_t d);
    logic          err;
    pu_pkg::data_t rdata;
    repeat (STAGES + 2) @(negedge clk);  // fixed latency, nothing to poll
    apb_read(`PU_ADDR_QUOT, rdata, err);
    check_flag("pslverr on quotient read", err, 1'b0);
    check_value("prdata quotient", rdata, n / d);
    apb_read(`PU_ADDR_REM, rdata, err);
    check_flag("pslverr on remainder read", err, 1'b0);
    check_value("prdata remainder", rdata, n % d);
  endtask

  task automatic check_invalid();
    logic          err;
    pu_pkg::data_t rdata;
    repeat (STAGES + 2) @(negedge clk);
    apb_read(`PU_ADDR_QUOT, rdata, err);
    check_flag("pslverr on invalid quotient read", err, 1'b1);
  endtask

  // ==============================
  // tests
  // ==============================
  task automatic test_reset();
    check_flag("pready after reset", pready, 1'b0);
    check_flag("pslverr after reset", pslverr, 1'b0);
    check_value("prdata after reset", prdata, 0);
    check_invalid();  // reset leaves 0/0 in the pipe
  endtask

  task automatic test_directed();
    pu_pkg::data_t nums [4] = '{32'd100, 32'hFFFF_FFFF, 32'd5, 32'd0};
    pu_pkg::data_t dens [4] = '{32'd7, 32'd1, 32'd9, 32'd3};
    for (int i = 0; i < 4; i++) begin
      commit_pair(`PU_ADDR_NUMER, nums[i], `PU_ADDR_DENOM, dens[i]);
      check_division(nums[i], dens[i]);
    end
  endtask

  task automatic test_invalid();
    pu_pkg::apb_addr_t naddr [3] = '{`PU_ADDR_NUMER, `PU_ADDR_NUMER_INV, `PU_ADDR_NUMER};
    pu_pkg::apb_addr_t daddr [3] = '{`PU_ADDR_DENOM, `PU_ADDR_DENOM, `PU_ADDR_DENOM_INV};
    pu_pkg::data_t     dens  [3] = '{32'd0, 32'd5, 32'd5};
    for (int i = 0; i < 3; i++) begin
      commit_pair(naddr[i], 32'd42, daddr[i], dens[i]);
      check_invalid();
      commit_pair(`PU_ADDR_NUMER, 32'd42 + i, `PU_ADDR_DENOM, 32'd5);
      check_division(32'd42 + i, 32'd5);  // a clean pair clears the flag
    end
  endtask

  task automatic test_back_to_back();
    // the numerator stays latched, so two denominator writes commit two pairs
    write_ok(`PU_ADDR_NUMER, 32'd1_000_000);
    write_ok(`PU_ADDR_DENOM, 32'd3);
    write_ok(`PU_ADDR_DENOM, 32'd977);
    check_division(32'd1_000_000, 32'd977);
  endtask

  task automatic test_random();
    pu_pkg::data_t n;
    pu_pkg::data_t d;
    for (int i = 0; i < RANDOM_PAIRS; i++) begin
      n = $random(seed);
      d = $random(seed);
      d = d >> ($random(seed) & 31);  // spread the quotient over its range
      if (d == '0)
        d = 32'd1;
      commit_pair(`PU_ADDR_NUMER, n, `PU_ADDR_DENOM, d);
      check_division(n, d);
    end
  endtask

  task automatic test_unmapped();
    logic          err;
    pu_pkg::data_t rdata;
    apb_read(8'h1C, rdata, err);
    check_flag("pslverr on unmapped read", err, 1'b1);
    check_value("prdata on unmapped read", rdata, 0);
    apb_write(8'h1C, 32'hDEAD_BEEF, err, rdata);
    check_flag("pslverr on unmapped write", err, 1'b1);
    check_value("prdata on unmapped write", rdata, 0);
    commit_pair(`PU_ADDR_NUMER, 32'd1000, `PU_ADDR_DENOM, 32'd33);
    check_division(32'd1000, 32'd33);
  endtask

  initial begin
    seed    = 32'h58e95e0f;
    clk     = 1'b0;
    rst     = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (5) @(negedge clk);
    rst = 1'b0;
    test_reset();
    test_directed();
    test_invalid();
    test_back_to_back();
    test_random();
    test_unmapped();
    $display("Test passed");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+include
src/pu_pkg.sv
src/pu_bus_if.sv
src/div_pipe.sv
src/pu_div.sv
src/apb_pu_bridge.sv
src/pu_div_apb_top.sv
verification/tb_pu_div.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_pu_div
FILELIST  := filelist.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
